//--- rtl/afu_cmd_pkg.sv
/*
 * Command controller package: class indices, queue and tag sizes,
 * width types and the command and response line structs
 */
package afu_cmd_pkg;

	localparam int NUM_CLASSES = 4;

	// Width types
	typedef logic [1:0]  class_t;
	typedef logic [31:0] addr_t;
	typedef logic [7:0]  cmd_code_t;
	typedef logic [2:0]  tag_t;
	typedef logic [3:0]  credit_t;
	typedef logic [7:0]  rsp_code_t;

	// Lower index wins arbitration
	localparam class_t CLASS_RESTART = 2'd0;
	localparam class_t CLASS_WED     = 2'd1;
	localparam class_t CLASS_WRITE   = 2'd2;
	localparam class_t CLASS_READ    = 2'd3;

	localparam int CLASS_QUEUE_DEPTH = 8;
	localparam int BURST_QUEUE_DEPTH = 16;
	localparam int BURST_HEADROOM    = 8;
	localparam int NUM_TAGS          = 8;
	localparam credit_t INIT_CREDITS = 4'd4;
	localparam int RSP_DELAY         = 4;

	typedef struct packed {
		logic      valid;
		class_t    cls;
		addr_t     address;
		cmd_code_t code;
	} cmd_line_t;

	typedef struct packed {
		cmd_line_t cmd;
		tag_t      tag;
	} bus_cmd_t;

	typedef struct packed {
		logic      valid;
		tag_t      tag;
		rsp_code_t code;
		credit_t   credits;
	} bus_rsp_t;

	typedef struct packed {
		logic      valid;
		tag_t      tag;
		rsp_code_t code;
	} class_rsp_t;

endpackage

//--- rtl/cmd_queue.sv
/*
 * Show-ahead command queue, circular buffer with an occupancy count
 */
`timescale 1ns/1ps

module cmd_queue #(
	parameter int DEPTH    = 8,
	parameter int HEADROOM = 2
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   push,
	input  afu_cmd_pkg::cmd_line_t line_in,
	input  logic                   pop,
	output afu_cmd_pkg::cmd_line_t line_out,
	output logic                   empty,
	output logic                   almost_full,
	output logic                   full
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	afu_cmd_pkg::cmd_line_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	assign full        = (count == CNT_W'(DEPTH));
	assign empty       = (count == '0);
	assign almost_full = (count >= CNT_W'(DEPTH - HEADROOM));

	// Push into a full queue is dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// Head is visible without a read cycle
	assign line_out = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= line_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- rtl/cmd_arbiter.sv
/*
 * Fixed-priority arbiter, moves one class queue head per cycle
 * into the burst queue and stamps it with its class
 */
`timescale 1ns/1ps

module cmd_arbiter (
	input  logic                                                 clock,
	input  logic                                                 rstn,
	input  logic                                                 enable,
	input  afu_cmd_pkg::cmd_line_t [afu_cmd_pkg::NUM_CLASSES-1:0] heads,
	input  logic [afu_cmd_pkg::NUM_CLASSES-1:0]                   empties,
	input  logic                                                 burst_almost_full,
	output logic [afu_cmd_pkg::NUM_CLASSES-1:0]                   pops,
	output afu_cmd_pkg::cmd_line_t                                burst_line
);

	logic                   grant_ok;
	afu_cmd_pkg::cmd_line_t granted;

	assign grant_ok = enable && !burst_almost_full;

	// Walk from lowest priority up so the lowest index wins
	always_comb begin
		pops    = '0;
		granted = '0;
		for (int i = afu_cmd_pkg::NUM_CLASSES - 1; i >= 0; i--) begin
			if (grant_ok && !empties[i]) begin
				pops          = '0;
				pops[i]       = 1'b1;
				granted       = heads[i];
				granted.valid = 1'b1;
				granted.cls   = afu_cmd_pkg::class_t'(i);
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			burst_line <= '0;
		end else begin
			burst_line <= granted;
		end
	end

endmodule

//--- rtl/tag_table.sv
/*
 * Tag table, hands out the lowest free tag and remembers the class
 * of each outstanding command until its response releases it
 */
`timescale 1ns/1ps

module tag_table (
	input  logic                clock,
	input  logic                rstn,
	input  logic                alloc,
	input  afu_cmd_pkg::class_t alloc_cls,
	output logic                tag_free,
	output afu_cmd_pkg::tag_t   free_tag,
	input  logic                release_tag_valid,
	input  afu_cmd_pkg::tag_t   release_tag,
	output afu_cmd_pkg::class_t release_cls
);

	logic [afu_cmd_pkg::NUM_TAGS-1:0] busy;
	afu_cmd_pkg::class_t              tag_cls [afu_cmd_pkg::NUM_TAGS];

	assign tag_free = !(&busy);

	// Lowest free tag
	always_comb begin
		free_tag = '0;
		for (int i = afu_cmd_pkg::NUM_TAGS - 1; i >= 0; i--) begin
			if (!busy[i]) begin
				free_tag = afu_cmd_pkg::tag_t'(i);
			end
		end
	end

	// Class lookup for the response path, same cycle
	assign release_cls = tag_cls[release_tag];

	always_ff @(posedge clock) begin
		if (alloc) begin
			tag_cls[free_tag] <= alloc_cls;
		end
	end

	////////////////////////////////////////
	// Busy bits
	////////////////////////////////////////

	// Allocated tag is free and released tag is busy, so the two never collide
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy <= '0;
		end else begin
			if (release_tag_valid) begin
				busy[release_tag] <= 1'b0;
			end
			if (alloc && tag_free) begin
				busy[free_tag] <= 1'b1;
			end
		end
	end

endmodule

//--- rtl/cmd_issue.sv
/*
 * Issue stage, pops the burst queue when a credit and a tag are
 * available and registers the tagged command onto the bus
 */
`timescale 1ns/1ps

module cmd_issue (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   enable,
	input  afu_cmd_pkg::cmd_line_t head,
	input  logic                   empty,
	input  logic                   tag_free,
	input  afu_cmd_pkg::tag_t      free_tag,
	input  logic                   credit_return_valid,
	input  afu_cmd_pkg::credit_t   credit_return,
	output logic                   pop,
	output logic                   alloc,
	output afu_cmd_pkg::bus_cmd_t  cmd_out
);

	afu_cmd_pkg::credit_t credits;
	afu_cmd_pkg::credit_t credit_add;
	afu_cmd_pkg::credit_t credit_sub;

	assign pop   = enable && !empty && tag_free && (credits != '0);
	assign alloc = pop;

	// Return and use may land on the same edge
	assign credit_add = credit_return_valid ? credit_return : '0;
	assign credit_sub = afu_cmd_pkg::credit_t'(pop);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			credits <= afu_cmd_pkg::INIT_CREDITS;
		end else begin
			credits <= credits + credit_add - credit_sub;
		end
	end

	////////////////////////////////////////
	// Bus command register
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cmd_out <= '0;
		end else begin
			cmd_out.cmd       <= head;
			cmd_out.cmd.valid <= pop;
			cmd_out.tag       <= free_tag;
		end
	end

endmodule

//--- rtl/rsp_route.sv
/*
 * Response router, releases the tag and returns credits, then delays
 * the response and strobes the output of the issuing class
 */
`timescale 1ns/1ps

module rsp_route (
	input  logic                                                  clock,
	input  logic                                                  rstn,
	input  logic                                                  enable,
	input  afu_cmd_pkg::bus_rsp_t                                 rsp_in,
	output logic                                                  release_tag_valid,
	output afu_cmd_pkg::tag_t                                     release_tag,
	input  afu_cmd_pkg::class_t                                   release_cls,
	output logic                                                  credit_return_valid,
	output afu_cmd_pkg::credit_t                                  credit_return,
	output afu_cmd_pkg::class_rsp_t [afu_cmd_pkg::NUM_CLASSES-1:0] rsp_out
);

	typedef struct packed {
		afu_cmd_pkg::class_t     cls;
		afu_cmd_pkg::class_rsp_t rsp;
	} rsp_stage_t;

	// Stage 0 is the latch, the rest form the delay line
	rsp_stage_t [afu_cmd_pkg::RSP_DELAY:0] stage;

	// Tag and credits go back on the latch edge
	assign release_tag_valid   = rsp_in.valid;
	assign release_tag         = rsp_in.tag;
	assign credit_return_valid = rsp_in.valid;
	assign credit_return       = rsp_in.credits;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			stage <= '0;
		end else if (!enable) begin
			stage <= '0;
		end else begin
			stage[0].cls       <= release_cls;
			stage[0].rsp.valid <= rsp_in.valid;
			stage[0].rsp.tag   <= rsp_in.tag;
			stage[0].rsp.code  <= rsp_in.code;
			for (int i = 1; i <= afu_cmd_pkg::RSP_DELAY; i++) begin
				stage[i] <= stage[i-1];
			end
		end
	end

	// Only the issuing class sees the strobe
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rsp_out <= '0;
		end else begin
			for (int c = 0; c < afu_cmd_pkg::NUM_CLASSES; c++) begin
				rsp_out[c]       <= stage[afu_cmd_pkg::RSP_DELAY].rsp;
				rsp_out[c].valid <= enable && stage[afu_cmd_pkg::RSP_DELAY].rsp.valid &&
					(stage[afu_cmd_pkg::RSP_DELAY].cls == afu_cmd_pkg::class_t'(c));
			end
		end
	end

endmodule

//--- rtl/afu_cmd_top.sv
/*
 * Command side of the bus controller: class queues, arbiter,
 * burst queue, tag table, issue stage and response routing
 */
`timescale 1ns/1ps

module afu_cmd_top (
	input  logic                                                  clock,
	input  logic                                                  rstn,
	input  logic                                                  enable,
	input  afu_cmd_pkg::cmd_line_t [afu_cmd_pkg::NUM_CLASSES-1:0]  cmd_in,
	input  afu_cmd_pkg::bus_rsp_t                                 rsp_in,
	output afu_cmd_pkg::bus_cmd_t                                 cmd_out,
	output afu_cmd_pkg::class_rsp_t [afu_cmd_pkg::NUM_CLASSES-1:0] rsp_out,
	output logic [afu_cmd_pkg::NUM_CLASSES-1:0]                    queue_full
);

	logic                                                 enabled;
	afu_cmd_pkg::cmd_line_t [afu_cmd_pkg::NUM_CLASSES-1:0] heads;
	logic [afu_cmd_pkg::NUM_CLASSES-1:0]                   empties;
	logic [afu_cmd_pkg::NUM_CLASSES-1:0]                   pops;
	afu_cmd_pkg::cmd_line_t                                burst_line;
	afu_cmd_pkg::cmd_line_t                                burst_head;
	logic                                                 burst_empty;
	logic                                                 burst_almost_full;
	logic                                                 burst_pop;
	logic                                                 alloc;
	logic                                                 tag_free;
	afu_cmd_pkg::tag_t                                     free_tag;
	logic                                                 release_tag_valid;
	afu_cmd_pkg::tag_t                                     release_tag;
	afu_cmd_pkg::class_t                                   release_cls;
	logic                                                 credit_return_valid;
	afu_cmd_pkg::credit_t                                  credit_return;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enable;
		end
	end

	////////////////////////////////////////
	// Class queues
	////////////////////////////////////////

	for (genvar i = 0; i < afu_cmd_pkg::NUM_CLASSES; i++) begin : g_class_queue
		cmd_queue #(
			.DEPTH   (afu_cmd_pkg::CLASS_QUEUE_DEPTH),
			.HEADROOM(2)
		) i_cmd_queue (
			.clock      (clock),
			.rstn       (rstn),
			.push       (cmd_in[i].valid),
			.line_in    (cmd_in[i]),
			.pop        (pops[i]),
			.line_out   (heads[i]),
			.empty      (empties[i]),
			.almost_full(),
			.full       (queue_full[i])
		);
	end

	cmd_arbiter i_cmd_arbiter (
		.clock            (clock),
		.rstn             (rstn),
		.enable           (enabled),
		.heads            (heads),
		.empties          (empties),
		.burst_almost_full(burst_almost_full),
		.pops             (pops),
		.burst_line       (burst_line)
	);

	////////////////////////////////////////
	// Burst queue and issue
	////////////////////////////////////////

	cmd_queue #(
		.DEPTH   (afu_cmd_pkg::BURST_QUEUE_DEPTH),
		.HEADROOM(afu_cmd_pkg::BURST_HEADROOM)
	) i_burst_queue (
		.clock      (clock),
		.rstn       (rstn),
		.push       (burst_line.valid),
		.line_in    (burst_line),
		.pop        (burst_pop),
		.line_out   (burst_head),
		.empty      (burst_empty),
		.almost_full(burst_almost_full),
		.full       ()
	);

	tag_table i_tag_table (
		.clock            (clock),
		.rstn             (rstn),
		.alloc            (alloc),
		.alloc_cls        (burst_head.cls),
		.tag_free         (tag_free),
		.free_tag         (free_tag),
		.release_tag_valid(release_tag_valid),
		.release_tag      (release_tag),
		.release_cls      (release_cls)
	);

	cmd_issue i_cmd_issue (
		.clock              (clock),
		.rstn               (rstn),
		.enable             (enabled),
		.head               (burst_head),
		.empty              (burst_empty),
		.tag_free           (tag_free),
		.free_tag           (free_tag),
		.credit_return_valid(credit_return_valid),
		.credit_return      (credit_return),
		.pop                (burst_pop),
		.alloc              (alloc),
		.cmd_out            (cmd_out)
	);

	rsp_route i_rsp_route (
		.clock              (clock),
		.rstn               (rstn),
		.enable             (enabled),
		.rsp_in             (rsp_in),
		.release_tag_valid  (release_tag_valid),
		.release_tag        (release_tag),
		.release_cls        (release_cls),
		.credit_return_valid(credit_return_valid),
		.credit_return      (credit_return),
		.rsp_out            (rsp_out)
	);

endmodule

//--- sim/afu_cmd_tb.sv
/*
 * Testbench for the command controller that replays the case file
 * and checks issued commands, their tags and the routed responses
 */
`timescale 1ns/1ps

module afu_cmd_tb;

	localparam int ISSUE_TIMEOUT = 50;
	localparam int RSP_TIMEOUT   = 20;
	localparam int RSP_LATENCY   = 2 + afu_cmd_pkg::RSP_DELAY;

	logic                                                  clock;
	logic                                                  rstn;
	logic                                                  enable;
	afu_cmd_pkg::cmd_line_t [afu_cmd_pkg::NUM_CLASSES-1:0]  cmd_in;
	afu_cmd_pkg::bus_rsp_t                                 rsp_in;
	afu_cmd_pkg::bus_cmd_t                                 cmd_out;
	afu_cmd_pkg::class_rsp_t [afu_cmd_pkg::NUM_CLASSES-1:0] rsp_out;
	logic [afu_cmd_pkg::NUM_CLASSES-1:0]                   queue_full;

	// Output events stamped with the edge that produced them
	afu_cmd_pkg::bus_cmd_t   issued_q [$];
	afu_cmd_pkg::class_t     rsp_cls_q [$];
	afu_cmd_pkg::class_rsp_t rsp_q [$];
	int                      rsp_stamp_q [$];
	int                      cycle = 0;

	// Reference model of tags and credits
	logic [afu_cmd_pkg::NUM_TAGS-1:0] model_busy;
	int                               model_credits;
	int                               sent_stamp [afu_cmd_pkg::NUM_TAGS];

	int                      fd;
	int                      fields;
	string                   line;
	logic [3:0]              op;
	afu_cmd_pkg::class_t     cls_v;
	afu_cmd_pkg::tag_t       tag_v;
	logic [7:0]              code_v;
	afu_cmd_pkg::credit_t    cr_v;
	afu_cmd_pkg::addr_t      addr_v;
	afu_cmd_pkg::bus_cmd_t   exp_cmd;
	afu_cmd_pkg::bus_cmd_t   got_cmd;
	afu_cmd_pkg::class_rsp_t exp_rsp;
	afu_cmd_pkg::class_rsp_t got_rsp;
	afu_cmd_pkg::class_t     got_cls;
	int                      got_stamp;

	afu_cmd_top i_afu_cmd_top (
		.clock     (clock),
		.rstn      (rstn),
		.enable    (enable),
		.cmd_in    (cmd_in),
		.rsp_in    (rsp_in),
		.cmd_out   (cmd_out),
		.rsp_out   (rsp_out),
		.queue_full(queue_full)
	);

	initial begin
		clock = 1'b0;
	end

	always #4 clock = ~clock;

	// Outputs read at the edge still hold the previous cycle's values
	always @(posedge clock) begin
		if (rstn) begin
			if (cmd_out.cmd.valid) begin
				issued_q.push_back(cmd_out);
			end
			for (int c = 0; c < afu_cmd_pkg::NUM_CLASSES; c++) begin
				if (rsp_out[c].valid) begin
					rsp_cls_q.push_back(afu_cmd_pkg::class_t'(c));
					rsp_q.push_back(rsp_out[c]);
					rsp_stamp_q.push_back(cycle);
				end
			end
		end
		cycle = cycle + 1;
	end

	////////////////////////////////////////
	// Helpers and compare tasks
	////////////////////////////////////////

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] got);
		report_failure($sformatf("error at %0d ns: %s expected %0h got %0h",
			$time, name, exp, got));
	endtask

	// Strobes last one cycle
	task automatic next_cycle();
		@(posedge clock);
		@(negedge clock);
		for (int c = 0; c < afu_cmd_pkg::NUM_CLASSES; c++) begin
			cmd_in[c].valid = 1'b0;
		end
		rsp_in.valid = 1'b0;
	endtask

	function automatic afu_cmd_pkg::tag_t lowest_free();
		afu_cmd_pkg::tag_t t;
		logic              found;
		t     = '0;
		found = 1'b0;
		for (int i = 0; i < afu_cmd_pkg::NUM_TAGS; i++) begin
			if (!model_busy[i] && !found) begin
				t     = afu_cmd_pkg::tag_t'(i);
				found = 1'b1;
			end
		end
		return t;
	endfunction

	task automatic check_cmd(input afu_cmd_pkg::bus_cmd_t exp, input afu_cmd_pkg::bus_cmd_t got);
		if (got.cmd.cls != exp.cmd.cls) begin
			value_error("cmd_out.cmd.cls", exp.cmd.cls, got.cmd.cls);
		end
		if (got.cmd.address != exp.cmd.address) begin
			value_error("cmd_out.cmd.address", exp.cmd.address, got.cmd.address);
		end
		if (got.cmd.code != exp.cmd.code) begin
			value_error("cmd_out.cmd.code", exp.cmd.code, got.cmd.code);
		end
		if (got.tag != exp.tag) begin
			value_error("cmd_out.tag", exp.tag, got.tag);
		end
	endtask

	task automatic check_rsp(input afu_cmd_pkg::class_t exp_cls, input afu_cmd_pkg::class_rsp_t exp,
			input afu_cmd_pkg::class_t got_cls_in, input afu_cmd_pkg::class_rsp_t got);
		if (got_cls_in != exp_cls) begin
			value_error("rsp_out class", exp_cls, got_cls_in);
		end
		if (got.tag != exp.tag) begin
			value_error($sformatf("rsp_out[%0d].tag", exp_cls), exp.tag, got.tag);
		end
		if (got.code != exp.code) begin
			value_error($sformatf("rsp_out[%0d].code", exp_cls), exp.code, got.code);
		end
	endtask

	task automatic check_tag(input string name, input afu_cmd_pkg::tag_t exp,
			input afu_cmd_pkg::tag_t got);
		if (got != exp) begin
			value_error(name, exp, got);
		end
	endtask

	task automatic check_latency(input int exp, input int got);
		if (got != exp) begin
			value_error("rsp_out latency in cycles", exp, got);
		end
	endtask

	////////////////////////////////////////
	// Case replay
	////////////////////////////////////////

	initial begin
		enable        = 1'b0;
		cmd_in        = '0;
		rsp_in        = '0;
		rstn          = 1'b0;
		model_busy    = '0;
		model_credits = afu_cmd_pkg::INIT_CREDITS;
		repeat (8) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;

		fd = $fopen("sim/afu_cmd_cases.txt", "r");
		if (fd == 0) begin
			report_failure("cannot open the case file sim/afu_cmd_cases.txt");
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && line.getc(0) != "#") begin
				fields = $sscanf(line, "%h %h %h %h %h %h", op, cls_v, tag_v, code_v, cr_v, addr_v);
				if (fields != 6) begin
					report_failure($sformatf("malformed case line: %s", line));
				end
				case (op)
					4'h0: begin
						repeat (addr_v) next_cycle();
					end
					4'h1: begin
						if (queue_full[cls_v]) begin
							report_failure("case pushes into a full class queue");
						end
						cmd_in[cls_v].valid   = 1'b1;
						// The arbiter stamps the queue index over this class field
						cmd_in[cls_v].cls     = ~cls_v;
						cmd_in[cls_v].address = addr_v;
						cmd_in[cls_v].code    = code_v;
					end
					4'h2: begin
						rsp_in.valid   = 1'b1;
						rsp_in.tag     = tag_v;
						rsp_in.code    = code_v;
						rsp_in.credits = cr_v;
						sent_stamp[tag_v] = cycle;
						model_busy[tag_v] = 1'b0;
						model_credits     = model_credits + cr_v;
					end
					4'h3: begin
						enable = addr_v[0];
					end
					4'h4: begin
						if (model_credits == 0 || &model_busy) begin
							report_failure("case expects an issue with no credit or no tag left");
						end
						check_tag("tag in case file against model", lowest_free(), tag_v);
						for (int w = 0; issued_q.size() == 0; w++) begin
							if (w == ISSUE_TIMEOUT) begin
								report_failure("timeout waiting for a command on cmd_out");
							end
							next_cycle();
						end
						got_cmd             = issued_q.pop_front();
						exp_cmd             = '0;
						exp_cmd.cmd.valid   = 1'b1;
						exp_cmd.cmd.cls     = cls_v;
						exp_cmd.cmd.address = addr_v;
						exp_cmd.cmd.code    = code_v;
						exp_cmd.tag         = tag_v;
						check_cmd(exp_cmd, got_cmd);
						model_busy[tag_v] = 1'b1;
						model_credits     = model_credits - 1;
					end
					4'h5: begin
						for (int w = 0; rsp_q.size() == 0; w++) begin
							if (w == RSP_TIMEOUT) begin
								report_failure("timeout waiting for a response on rsp_out");
							end
							next_cycle();
						end
						got_cls       = rsp_cls_q.pop_front();
						got_rsp       = rsp_q.pop_front();
						got_stamp     = rsp_stamp_q.pop_front();
						exp_rsp       = '0;
						exp_rsp.valid = 1'b1;
						exp_rsp.tag   = tag_v;
						exp_rsp.code  = code_v;
						check_rsp(cls_v, exp_rsp, got_cls, got_rsp);
						check_latency(RSP_LATENCY, got_stamp - sent_stamp[tag_v]);
					end
					4'h6: begin
						for (int w = 0; w < addr_v; w++) begin
							next_cycle();
							if (issued_q.size() != 0) begin
								report_failure("a command was issued while it should have been held");
							end
							if (rsp_q.size() != 0) begin
								report_failure("a response appeared while none was expected");
							end
						end
					end
					default: begin
						report_failure($sformatf("unknown op in case line: %s", line));
					end
				endcase
			end
		end
		$fclose(fd);

		if (issued_q.size() != 0 || rsp_q.size() != 0) begin
			report_failure("outputs were left unchecked at the end of the cases");
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

//--- afu_cmd.f
rtl/afu_cmd_pkg.sv
rtl/cmd_queue.sv
rtl/cmd_arbiter.sv
rtl/tag_table.sv
rtl/cmd_issue.sv
rtl/rsp_route.sv
rtl/afu_cmd_top.sv
sim/afu_cmd_tb.sv

//--- sim/afu_cmd_cases.txt
# columns, all hex: op class tag code credits address
# op 0 idle, 1 push, 2 response, 3 enable, 4 expect issue, 5 expect response, 6 quiet
# ops 0 and 6 take the cycle count and op 3 the enable level in the address column
3 0 0 00 0 00000001
0 0 0 00 0 00000002
1 0 0 20 0 00001000
4 0 0 20 0 00001000
2 0 0 a0 1 00000000
5 0 0 a0 0 00000000
1 1 0 21 0 00002040
4 1 0 21 0 00002040
2 0 0 a1 1 00000000
5 1 0 a1 0 00000000
1 2 0 22 0 00003080
4 2 0 22 0 00003080
2 0 0 a2 1 00000000
5 2 0 a2 0 00000000
1 3 0 23 0 000040c0
4 3 0 23 0 000040c0
2 0 0 a3 1 00000000
5 3 0 a3 0 00000000
# all four classes in one cycle, then two more with no credit left
1 0 0 30 0 10000000
1 1 0 31 0 10000100
1 2 0 32 0 10000200
1 3 0 33 0 10000300
4 0 0 30 0 10000000
4 1 1 31 0 10000100
4 2 2 32 0 10000200
4 3 3 33 0 10000300
1 0 0 40 0 20000000
1 1 0 41 0 20000100
6 0 0 00 0 00000014
# tag 1 returns two credits and is reused
2 0 1 5a 2 00000000
4 0 1 40 0 20000000
4 1 4 41 0 20000100
5 1 1 5a 0 00000000
# enable low holds commands and drops responses
3 0 0 00 0 00000000
0 0 0 00 0 00000002
2 0 0 60 2 00000000
0 0 0 00 0 00000001
2 0 2 62 2 00000000
1 3 0 70 0 30000300
1 2 0 72 0 30000200
6 0 0 00 0 00000014
3 0 0 00 0 00000001
4 2 0 72 0 30000200
4 3 2 70 0 30000300
6 0 0 00 0 0000000a
